//--- source/mem_ctl_pkg.sv
package mem_ctl_pkg;

    localparam int XLEN       = 32;
    localparam int SPI_ADDR_W = 24;
    localparam int LEN_W      = 3;

    // Top address byte of the flash region, every other value maps to PSRAM
    localparam logic [7:0] FLASH_REGION = 8'h00;

    localparam logic [SPI_ADDR_W-1:0] INSTR_STEP = 4;
    localparam logic [LEN_W-1:0]      WORD_BYTES = 4;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h02,
        CMD_READ  = 8'h03
    } spi_cmd_e;

    // RISC-V funct3 of loads and stores
    typedef enum logic [2:0] {
        OP_B  = 3'b000,
        OP_H  = 3'b001,
        OP_W  = 3'b010,
        OP_BU = 3'b100,
        OP_HU = 3'b101
    } mem_op_e;

    typedef enum logic [2:0] {
        ACC_IDLE,
        ACC_ACTIVE,
        ACC_NEXT_INSTR,
        ACC_PAUSE,
        ACC_STOP
    } access_state_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_HEADER,
        PH_DATA,
        PH_HOLD
    } engine_phase_e;

    // Bus order puts the lowest address in the top byte
    function automatic logic [XLEN-1:0] byte_swap(input logic [XLEN-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

//--- source/data_lane_align.sv
`timescale 1ns/1ps

module data_lane_align (
    input  mem_ctl_pkg::mem_op_e           mem_flag,
    input  logic [mem_ctl_pkg::XLEN-1:0]   mem_wdata,
    input  logic [mem_ctl_pkg::XLEN-1:0]   raw_rdata,
    output logic [mem_ctl_pkg::LEN_W-1:0]  byte_count,
    output logic [mem_ctl_pkg::XLEN-1:0]   bus_wdata,
    output logic [mem_ctl_pkg::XLEN-1:0]   load_data
);

    logic [mem_ctl_pkg::XLEN-1:0] store_le;
    logic [mem_ctl_pkg::XLEN-1:0] load_le;

    assign store_le = mem_ctl_pkg::byte_swap(mem_wdata);

    // Narrow reads land in the low bytes of the shift register
    assign load_le = mem_ctl_pkg::byte_swap(raw_rdata);

    always_comb begin
        case (mem_flag)
            mem_ctl_pkg::OP_B, mem_ctl_pkg::OP_BU: byte_count = 1;
            mem_ctl_pkg::OP_H, mem_ctl_pkg::OP_HU: byte_count = 2;
            default:                               byte_count = mem_ctl_pkg::WORD_BYTES;
        endcase
    end

    // First byte on the wire is the one at the lowest address
    always_comb begin
        case (mem_flag)
            mem_ctl_pkg::OP_B: bus_wdata = {store_le[31:24], 24'h0};
            mem_ctl_pkg::OP_H: bus_wdata = {store_le[31:16], 16'h0};
            default:           bus_wdata = store_le;
        endcase
    end

    always_comb begin
        case (mem_flag)
            mem_ctl_pkg::OP_B:  load_data = {{24{load_le[31]}}, load_le[31:24]};
            mem_ctl_pkg::OP_BU: load_data = {24'h0, load_le[31:24]};
            mem_ctl_pkg::OP_H:  load_data = {{16{load_le[31]}}, load_le[31:16]};
            mem_ctl_pkg::OP_HU: load_data = {16'h0, load_le[31:16]};
            default:            load_data = load_le;
        endcase
    end

endmodule

//--- source/prefetch_buffer.sv
`timescale 1ns/1ps

module prefetch_buffer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mem_ctl_pkg::SPI_ADDR_W-1:0]  instr_addr,
    input  logic [mem_ctl_pkg::SPI_ADDR_W-1:0]  fetch_addr,
    input  logic [mem_ctl_pkg::XLEN-1:0]        word,
    input  logic                                load_current,
    input  logic                                load_next,
    input  logic                                promote,
    input  logic                                flush,
    output logic [mem_ctl_pkg::XLEN-1:0]        instr_data,
    output logic                                cur_valid,
    output logic                                addr_hit,
    output logic                                seq_hit,
    output logic                                next_valid
);

    logic [mem_ctl_pkg::SPI_ADDR_W-1:0] cur_addr;
    logic [mem_ctl_pkg::SPI_ADDR_W-1:0] seq_addr;
    logic [mem_ctl_pkg::XLEN-1:0]       next_word;

    assign seq_addr = cur_addr + mem_ctl_pkg::INSTR_STEP;
    assign addr_hit = (instr_addr == cur_addr);
    assign seq_hit  = (instr_addr == seq_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_valid  <= 1'b0;
            next_valid <= 1'b0;
        end else if (flush) begin
            cur_valid  <= 1'b0;
            next_valid <= 1'b0;
        end else if (load_current) begin
            cur_valid  <= 1'b1;
            next_valid <= 1'b0;
        end else if (load_next) begin
            next_valid <= 1'b1;
        end else if (promote) begin
            cur_valid  <= next_valid;
            next_valid <= 1'b0;
        end
    end

    // Words arrive in bus order and are kept little-endian
    always_ff @(posedge clk) begin
        if (load_current) begin
            cur_addr   <= fetch_addr;
            instr_data <= mem_ctl_pkg::byte_swap(word);
        end else if (promote) begin
            cur_addr   <= seq_addr;
            instr_data <= next_word;
        end
        if (load_next) begin
            next_word <= mem_ctl_pkg::byte_swap(word);
        end
    end

endmodule

//--- source/access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mem_ctl_pkg::SPI_ADDR_W-1:0]  instr_addr,
    input  logic [mem_ctl_pkg::XLEN-1:0]        mem_addr,
    input  logic                                mem_we,
    input  logic                                mem_re,
    output logic [mem_ctl_pkg::XLEN-1:0]        mem_rdata,
    output logic                                mem_ready,
    // Engine side
    output logic                                start,
    output logic                                stop,
    output logic                                cont,
    output logic                                write_en,
    output logic                                target_ram,
    output logic [mem_ctl_pkg::SPI_ADDR_W-1:0]  addr,
    output logic [mem_ctl_pkg::LEN_W-1:0]       byte_count,
    output logic [mem_ctl_pkg::XLEN-1:0]        wdata,
    input  logic                                done,
    // Prefetch buffer side
    input  logic                                cur_valid,
    input  logic                                addr_hit,
    input  logic                                seq_hit,
    input  logic                                next_valid,
    output logic                                load_current,
    output logic                                load_next,
    output logic                                promote,
    output logic                                flush,
    // Lane align side
    input  logic [mem_ctl_pkg::LEN_W-1:0]       store_count,
    input  logic [mem_ctl_pkg::XLEN-1:0]        store_word,
    input  logic [mem_ctl_pkg::XLEN-1:0]        load_data
);

    mem_ctl_pkg::access_state_e state;
    logic is_instr;
    logic pend_we;
    logic pend_re;

    logic strobe;
    logic data_req;
    logic jump;
    logic in_burst;
    logic launch_data;
    logic launch_instr;
    logic data_done;

    assign strobe   = mem_we | mem_re;
    assign data_req = strobe | pend_we | pend_re;
    assign jump     = !addr_hit && !seq_hit;
    assign in_burst = (state == mem_ctl_pkg::ACC_NEXT_INSTR) || (state == mem_ctl_pkg::ACC_PAUSE);

    assign launch_data  = (state == mem_ctl_pkg::ACC_IDLE) && data_req;
    assign launch_instr = (state == mem_ctl_pkg::ACC_IDLE) && !data_req
                          && !(cur_valid && addr_hit) && !(seq_hit && next_valid);
    assign data_done    = (state == mem_ctl_pkg::ACC_ACTIVE) && !is_instr && done;

    // Buffer strobes act in the same cycle so a prefetched step costs one cycle
    assign load_current = (state == mem_ctl_pkg::ACC_ACTIVE) && is_instr && done;
    assign load_next    = (state == mem_ctl_pkg::ACC_NEXT_INSTR) && done;
    assign promote      = !data_req && seq_hit && next_valid
                          && ((state == mem_ctl_pkg::ACC_PAUSE) || (state == mem_ctl_pkg::ACC_IDLE));
    assign flush        = !data_req && jump && in_burst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mem_ctl_pkg::ACC_IDLE;
            is_instr  <= 1'b0;
            pend_we   <= 1'b0;
            pend_re   <= 1'b0;
            start     <= 1'b0;
            stop      <= 1'b0;
            cont      <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            start     <= 1'b0;
            stop      <= 1'b0;
            cont      <= 1'b0;
            mem_ready <= 1'b0;
            // Strobes last one cycle, hold them until the access starts
            if (mem_we) pend_we <= 1'b1;
            if (mem_re) pend_re <= 1'b1;

            case (state)
                mem_ctl_pkg::ACC_IDLE: begin
                    if (launch_data) begin
                        start    <= 1'b1;
                        is_instr <= 1'b0;
                        pend_we  <= 1'b0;
                        pend_re  <= 1'b0;
                        state    <= mem_ctl_pkg::ACC_ACTIVE;
                    end else if (launch_instr) begin
                        start    <= 1'b1;
                        is_instr <= 1'b1;
                        state    <= mem_ctl_pkg::ACC_ACTIVE;
                    end
                end
                mem_ctl_pkg::ACC_ACTIVE: begin
                    if (is_instr && strobe) begin
                        stop  <= 1'b1;
                        state <= mem_ctl_pkg::ACC_STOP;
                    end else if (done && is_instr) begin
                        cont  <= 1'b1;
                        state <= mem_ctl_pkg::ACC_NEXT_INSTR;
                    end else if (done) begin
                        mem_ready <= 1'b1;
                        stop      <= 1'b1;
                        state     <= mem_ctl_pkg::ACC_IDLE;
                    end
                end
                mem_ctl_pkg::ACC_NEXT_INSTR: begin
                    if (strobe || jump) begin
                        stop  <= 1'b1;
                        state <= mem_ctl_pkg::ACC_STOP;
                    end else if (done) begin
                        state <= mem_ctl_pkg::ACC_PAUSE;
                    end
                end
                mem_ctl_pkg::ACC_PAUSE: begin
                    if (strobe || jump) begin
                        stop  <= 1'b1;
                        state <= mem_ctl_pkg::ACC_STOP;
                    end else if (seq_hit) begin
                        cont  <= 1'b1;
                        state <= mem_ctl_pkg::ACC_NEXT_INSTR;
                    end
                end
                default: state <= mem_ctl_pkg::ACC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch_data) begin
            addr       <= mem_addr[mem_ctl_pkg::SPI_ADDR_W-1:0];
            write_en   <= mem_we | pend_we;
            target_ram <= (mem_addr[mem_ctl_pkg::XLEN-1 -: 8] != mem_ctl_pkg::FLASH_REGION);
            byte_count <= store_count;
            wdata      <= store_word;
        end else if (launch_instr) begin
            addr       <= instr_addr;
            write_en   <= 1'b0;
            target_ram <= 1'b0;
            byte_count <= mem_ctl_pkg::WORD_BYTES;
        end
        if (data_done) begin
            mem_rdata <= load_data;
        end
    end

endmodule

//--- source/spi_engine.sv
`timescale 1ns/1ps

module spi_engine (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                stop,
    input  logic                                cont,
    input  logic                                write_en,
    input  logic                                target_ram,
    input  logic [mem_ctl_pkg::SPI_ADDR_W-1:0]  addr,
    input  logic [mem_ctl_pkg::LEN_W-1:0]       byte_count,
    input  logic [mem_ctl_pkg::XLEN-1:0]        wdata,
    output logic [mem_ctl_pkg::XLEN-1:0]        rdata,
    output logic                                done,
    output logic                                spi_sclk,
    output logic                                spi_mosi,
    output logic                                flash_cs_n,
    output logic                                ram_cs_n,
    input  logic                                spi_miso
);

    mem_ctl_pkg::engine_phase_e phase;
    mem_ctl_pkg::spi_cmd_e      cmd;

    logic [5:0]                   bit_cnt;
    logic                         cs_ram;
    logic                         shifting;
    logic                         last_bit;
    logic [mem_ctl_pkg::XLEN-1:0] tx_sr;
    logic [mem_ctl_pkg::XLEN-1:0] rx_sr;

    assign cmd      = write_en ? mem_ctl_pkg::CMD_WRITE : mem_ctl_pkg::CMD_READ;
    assign shifting = (phase == mem_ctl_pkg::PH_HEADER) || (phase == mem_ctl_pkg::PH_DATA);
    assign last_bit = (bit_cnt == 6'd1);

    // One chip select, routed by the target latched at start
    assign flash_cs_n = !((phase != mem_ctl_pkg::PH_IDLE) && !cs_ram);
    assign ram_cs_n   = !((phase != mem_ctl_pkg::PH_IDLE) && cs_ram);
    assign spi_mosi   = (phase != mem_ctl_pkg::PH_IDLE) && tx_sr[mem_ctl_pkg::XLEN-1];
    assign rdata      = rx_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= mem_ctl_pkg::PH_IDLE;
            bit_cnt  <= '0;
            spi_sclk <= 1'b0;
            cs_ram   <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (stop) begin
                phase    <= mem_ctl_pkg::PH_IDLE;
                spi_sclk <= 1'b0;
            end else begin
                case (phase)
                    mem_ctl_pkg::PH_IDLE: begin
                        if (start) begin
                            phase   <= mem_ctl_pkg::PH_HEADER;
                            bit_cnt <= 6'd32;
                            cs_ram  <= target_ram;
                        end
                    end
                    mem_ctl_pkg::PH_HEADER, mem_ctl_pkg::PH_DATA: begin
                        spi_sclk <= !spi_sclk;
                        // A bit ends on the falling edge
                        if (spi_sclk) begin
                            bit_cnt <= bit_cnt - 6'd1;
                            if (last_bit && phase == mem_ctl_pkg::PH_HEADER) begin
                                phase   <= mem_ctl_pkg::PH_DATA;
                                bit_cnt <= {byte_count, 3'b000};
                            end else if (last_bit) begin
                                phase <= mem_ctl_pkg::PH_HOLD;
                                done  <= 1'b1;
                            end
                        end
                    end
                    mem_ctl_pkg::PH_HOLD: begin
                        // Chip select stays low so a read burst can go on
                        if (cont) begin
                            phase   <= mem_ctl_pkg::PH_DATA;
                            bit_cnt <= 6'd32;
                        end
                    end
                    default: phase <= mem_ctl_pkg::PH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase == mem_ctl_pkg::PH_IDLE && start) begin
            tx_sr <= {cmd, addr};
        end else if (phase == mem_ctl_pkg::PH_HEADER && spi_sclk && last_bit) begin
            tx_sr <= wdata;
        end else if (shifting && spi_sclk) begin
            tx_sr <= {tx_sr[mem_ctl_pkg::XLEN-2:0], 1'b0};
        end
        // Sample MISO as SCLK rises
        if (phase == mem_ctl_pkg::PH_DATA && !spi_sclk) begin
            rx_sr <= {rx_sr[mem_ctl_pkg::XLEN-2:0], spi_miso};
        end
    end

endmodule

//--- source/mem_ctl_top.sv
`timescale 1ns/1ps

module mem_ctl_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mem_ctl_pkg::XLEN-1:0]   instr_addr,
    output logic [mem_ctl_pkg::XLEN-1:0]   instr_data,
    output logic                           instr_ready,
    input  logic [mem_ctl_pkg::XLEN-1:0]   mem_addr,
    input  logic [mem_ctl_pkg::XLEN-1:0]   mem_wdata,
    input  mem_ctl_pkg::mem_op_e           mem_flag,
    input  logic                           mem_we,
    input  logic                           mem_re,
    output logic [mem_ctl_pkg::XLEN-1:0]   mem_rdata,
    output logic                           mem_ready,
    output logic                           spi_sclk,
    output logic                           spi_mosi,
    input  logic                           spi_miso,
    output logic                           flash_cs_n,
    output logic                           ram_cs_n
);

    logic                               start, stop, cont, done;
    logic                               write_en, target_ram;
    logic [mem_ctl_pkg::SPI_ADDR_W-1:0] eng_addr;
    logic [mem_ctl_pkg::LEN_W-1:0]      eng_count, store_count;
    logic [mem_ctl_pkg::XLEN-1:0]       eng_wdata, eng_rdata;
    logic [mem_ctl_pkg::XLEN-1:0]       store_word, load_data;
    logic                               cur_valid, addr_hit, seq_hit, next_valid;
    logic                               load_current, load_next, promote, flush;

    // Only a word that belongs to the present address counts as ready
    assign instr_ready = cur_valid & addr_hit;

    access_sequencer u_seq (
        .clk, .rst_n,
        .instr_addr   (instr_addr[mem_ctl_pkg::SPI_ADDR_W-1:0]),
        .mem_addr, .mem_we, .mem_re, .mem_rdata, .mem_ready,
        .start, .stop, .cont, .write_en, .target_ram,
        .addr         (eng_addr),
        .byte_count   (eng_count),
        .wdata        (eng_wdata),
        .done,
        .cur_valid, .addr_hit, .seq_hit, .next_valid,
        .load_current, .load_next, .promote, .flush,
        .store_count, .store_word, .load_data
    );

    prefetch_buffer u_pfb (
        .clk, .rst_n,
        .instr_addr   (instr_addr[mem_ctl_pkg::SPI_ADDR_W-1:0]),
        .fetch_addr   (eng_addr),
        .word         (eng_rdata),
        .load_current, .load_next, .promote, .flush,
        .instr_data, .cur_valid, .addr_hit, .seq_hit, .next_valid
    );

    spi_engine u_spi (
        .clk, .rst_n,
        .start, .stop, .cont, .write_en, .target_ram,
        .addr         (eng_addr),
        .byte_count   (eng_count),
        .wdata        (eng_wdata),
        .rdata        (eng_rdata),
        .done,
        .spi_sclk, .spi_mosi, .flash_cs_n, .ram_cs_n, .spi_miso
    );

    data_lane_align u_align (
        .mem_flag, .mem_wdata,
        .raw_rdata    (eng_rdata),
        .byte_count   (store_count),
        .bus_wdata    (store_word),
        .load_data
    );

endmodule

//--- tests/spi_mem_model.sv
`timescale 1ns/1ps

module spi_mem_model #(
    parameter logic [31:0] SALT     = 32'h0,
    parameter bit          WRITABLE = 1'b1
) (
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    localparam int MEM_BYTES = 16384;

    logic [7:0]  mem [MEM_BYTES];
    logic [31:0] hdr;
    logic [23:0] addr;
    logic [7:0]  rx_byte;
    logic [7:0]  tx_byte;
    logic        is_write;
    int          bit_cnt;

    // Word at an aligned address a is (a ^ SALT) * golden ratio, little-endian
    initial begin
        logic [31:0] w;
        for (int a = 0; a < MEM_BYTES; a++) begin
            w = ((a & 32'hffff_fffc) ^ SALT) * 32'h9E37_79B1;
            mem[a] = w[8*(a%4) +: 8];
        end
        bit_cnt  = 0;
        tx_byte  = 8'h00;
        is_write = 1'b0;
    end

    // Only drive MISO while selected
    assign miso = !cs_n && tx_byte[7];

    always @(negedge cs_n) begin
        bit_cnt = 0;
        tx_byte = 8'h00;
    end

    // Command and address, then write data, are sampled on the rising edge
    always @(posedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt < 32) begin
                hdr = {hdr[30:0], mosi};
                if (bit_cnt == 31) begin
                    addr     = hdr[23:0];
                    is_write = (hdr[31:24] == mem_ctl_pkg::CMD_WRITE);
                end
            end else if (is_write) begin
                rx_byte = {rx_byte[6:0], mosi};
                if ((bit_cnt - 32) % 8 == 7) begin
                    if (WRITABLE) begin
                        mem[addr[13:0]] = rx_byte;
                    end
                    addr = addr + 24'd1;
                end
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    // Read data changes on the falling edge, bursts run on without limit
    always @(negedge sclk) begin
        if (!cs_n && bit_cnt >= 32 && !is_write) begin
            if ((bit_cnt - 32) % 8 == 0) begin
                tx_byte = mem[addr[13:0]];
                addr    = addr + 24'd1;
            end else begin
                tx_byte = {tx_byte[6:0], 1'b0};
            end
        end
    end

endmodule

//--- tests/mem_ctl_properties.sv
`timescale 1ns/1ps

module mem_ctl_properties (
    input logic clk,
    input logic rst_n,
    input logic flash_cs_n,
    input logic ram_cs_n,
    input logic spi_sclk,
    input logic mem_ready
);

    // Only one chip may be selected
    assert property (@(posedge clk) disable iff (!rst_n) flash_cs_n || ram_cs_n)
        else $error("both chip selects low at %0t", $time);

    assert property (@(posedge clk) disable iff (!rst_n) mem_ready |=> !mem_ready)
        else $error("mem_ready high for two cycles at %0t", $time);

    // No clock on the bus while it is deselected
    assert property (@(posedge clk) disable iff (!rst_n) (flash_cs_n && ram_cs_n) |-> !spi_sclk)
        else $error("spi_sclk high with both chips deselected at %0t", $time);

endmodule

bind mem_ctl_top mem_ctl_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_cs_n (flash_cs_n),
    .ram_cs_n   (ram_cs_n),
    .spi_sclk   (spi_sclk),
    .mem_ready  (mem_ready)
);

//--- tests/mem_ctl_tb.sv
`timescale 1ns/1ps

module mem_ctl_tb;

    localparam int          MEM_BYTES     = 16384;
    localparam int          DIRECTED_OPS  = 36;
    localparam int          RANDOM_OPS    = 200;
    localparam int          NUM_OPS       = DIRECTED_OPS + RANDOM_OPS;
    localparam int          CYCLES_PER_OP = 200;
    localparam int          DWELL         = 80;
    localparam logic [31:0] RAM_BASE      = 32'h0100_0000;
    localparam logic [31:0] RAM_SALT      = 32'h5a5a_0000;

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          instr_addr;
    logic [31:0]          instr_data;
    logic                 instr_ready;
    logic [31:0]          mem_addr;
    logic [31:0]          mem_wdata;
    mem_ctl_pkg::mem_op_e mem_flag;
    logic                 mem_we;
    logic                 mem_re;
    logic [31:0]          mem_rdata;
    logic                 mem_ready;
    logic                 spi_sclk;
    logic                 spi_mosi;
    logic                 spi_miso;
    logic                 flash_cs_n;
    logic                 ram_cs_n;
    logic                 flash_miso;
    logic                 ram_miso;

    logic [7:0]  flash_img [MEM_BYTES];
    logic [7:0]  ram_img [MEM_BYTES];
    logic [31:0] lfsr_state;
    logic [31:0] exp_rdata;
    logic        load_pending;

    assign spi_miso = !flash_cs_n ? flash_miso : ram_miso;

    mem_ctl_top uut (
        .clk, .rst_n, .instr_addr, .instr_data, .instr_ready,
        .mem_addr, .mem_wdata, .mem_flag, .mem_we, .mem_re, .mem_rdata, .mem_ready,
        .spi_sclk, .spi_mosi, .spi_miso, .flash_cs_n, .ram_cs_n
    );

    spi_mem_model #(.SALT(32'h0), .WRITABLE(1'b0)) flash_mem (
        .sclk(spi_sclk), .cs_n(flash_cs_n), .mosi(spi_mosi), .miso(flash_miso)
    );

    spi_mem_model #(.SALT(RAM_SALT), .WRITABLE(1'b1)) ram_mem (
        .sclk(spi_sclk), .cs_n(ram_cs_n), .mosi(spi_mosi), .miso(ram_miso)
    );

    always #5 clk = ~clk;

    function automatic logic [7:0] fill_byte(input logic [31:0] salt, input int a);
        logic [31:0] w;
        w = ((a & 32'hffff_fffc) ^ salt) * 32'h9E37_79B1;
        return w[8*(a%4) +: 8];
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int width_of(input mem_ctl_pkg::mem_op_e op);
        case (op)
            mem_ctl_pkg::OP_B, mem_ctl_pkg::OP_BU: return 1;
            mem_ctl_pkg::OP_H, mem_ctl_pkg::OP_HU: return 2;
            default:                               return 4;
        endcase
    endfunction

    // Expected little-endian load value from the shadow images
    function automatic logic [31:0] ref_value(input logic ram, input logic [13:0] a,
                                              input mem_ctl_pkg::mem_op_e op);
        logic [7:0]  b [4];
        logic [13:0] idx;
        for (int k = 0; k < 4; k++) begin
            idx  = a + 14'(k);
            b[k] = ram ? ram_img[idx] : flash_img[idx];
        end
        case (op)
            mem_ctl_pkg::OP_B:  return {{24{b[0][7]}}, b[0]};
            mem_ctl_pkg::OP_BU: return {24'h0, b[0]};
            mem_ctl_pkg::OP_H:  return {{16{b[1][7]}}, b[1], b[0]};
            mem_ctl_pkg::OP_HU: return {16'h0, b[1], b[0]};
            default:            return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, expected));
        end
    endtask

    task automatic set_instr(input logic [31:0] addr);
        @(posedge clk);
        #1 instr_addr = addr;
    endtask

    task automatic wait_instr();
        do @(negedge clk); while (!instr_ready);
    endtask

    // A prefetched step must be ready one cycle after the address changes
    task automatic fetch(input logic [31:0] addr, input bit prefetched);
        set_instr(addr);
        if (prefetched) begin
            @(posedge clk);
            @(negedge clk);
            assert (instr_ready) else begin
                report_failure($sformatf("Prefetched word at %h was not ready after one cycle",
                                         addr));
            end
        end else begin
            wait_instr();
        end
    endtask

    task automatic data_access(input bit we, input mem_ctl_pkg::mem_op_e op,
                               input logic [31:0] addr, input logic [31:0] wdata);
        logic        ram;
        logic [13:0] idx;
        ram = (addr[31:24] != 8'h00);
        @(posedge clk);
        #1;
        if (we) begin
            load_pending = 1'b0;
            for (int k = 0; k < width_of(op); k++) begin
                idx = addr[13:0] + 14'(k);
                if (ram) begin
                    ram_img[idx] = wdata[8*k +: 8];
                end
            end
        end else begin
            exp_rdata    = ref_value(ram, addr[13:0], op);
            load_pending = 1'b1;
        end
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_flag  = op;
        mem_we    = we;
        mem_re    = !we;
        @(posedge clk);
        #1;
        mem_we = 1'b0;
        mem_re = 1'b0;
        do @(negedge clk); while (!mem_ready);
    endtask

    // Compare process
    always @(negedge clk) begin
        if (rst_n) begin
            if (instr_ready) begin
                check_value("instr_data", instr_data,
                            ref_value(1'b0, instr_addr[13:0], mem_ctl_pkg::OP_W));
            end
            if (mem_ready && load_pending) begin
                check_value("mem_rdata", mem_rdata, exp_rdata);
            end
        end
    end

    initial begin
        #(NUM_OPS * CYCLES_PER_OP * 10);
        report_failure("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        logic [31:0] off;
        logic [31:0] sel;
        mem_ctl_pkg::mem_op_e op;
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_addr   = '0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_flag     = mem_ctl_pkg::OP_W;
        mem_we       = 1'b0;
        mem_re       = 1'b0;
        load_pending = 1'b0;
        lfsr_state   = 32'h22a5_b4ae;
        for (int a = 0; a < MEM_BYTES; a++) begin
            flash_img[a] = fill_byte(32'h0, a);
            ram_img[a]   = fill_byte(RAM_SALT, a);
        end
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("flash_cs_n", 32'(flash_cs_n), 32'd1);
        check_value("ram_cs_n", 32'(ram_cs_n), 32'd1);
        check_value("spi_sclk", 32'(spi_sclk), 32'd0);
        check_value("mem_ready", 32'(mem_ready), 32'd0);
        check_value("instr_ready", 32'(instr_ready), 32'd0);

        // Sequential fetches, each step from the prefetched word
        fetch(32'h0, 1'b0);
        for (int i = 1; i < 8; i++) begin
            repeat (DWELL) @(posedge clk);
            fetch(32'(4 * i), 1'b1);
        end

        // Jump, then sequential again
        fetch(32'h1230, 1'b0);
        repeat (DWELL) @(posedge clk);
        fetch(32'h1234, 1'b1);
        repeat (DWELL) @(posedge clk);
        fetch(32'h1238, 1'b1);
        fetch(32'h0560, 1'b0);

        // Mixed width stores to PSRAM merged into words
        data_access(1'b1, mem_ctl_pkg::OP_W, RAM_BASE + 32'h100, 32'h1122_3344);
        data_access(1'b1, mem_ctl_pkg::OP_B, RAM_BASE + 32'h101, 32'h0000_00ee);
        data_access(1'b1, mem_ctl_pkg::OP_H, RAM_BASE + 32'h102, 32'h0000_beef);
        data_access(1'b0, mem_ctl_pkg::OP_W, RAM_BASE + 32'h100, 32'h0);
        data_access(1'b1, mem_ctl_pkg::OP_W, RAM_BASE + 32'h205, 32'hcafe_f00d);
        data_access(1'b0, mem_ctl_pkg::OP_W, RAM_BASE + 32'h204, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_W, RAM_BASE + 32'h208, 32'h0);

        // Sign and zero extension with the top bit set and clear
        data_access(1'b1, mem_ctl_pkg::OP_W, RAM_BASE + 32'h300, 32'h8001_7f80);
        data_access(1'b0, mem_ctl_pkg::OP_B, RAM_BASE + 32'h300, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_BU, RAM_BASE + 32'h300, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_B, RAM_BASE + 32'h301, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_H, RAM_BASE + 32'h302, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_HU, RAM_BASE + 32'h302, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_H, RAM_BASE + 32'h300, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_W, 32'h0000_0040, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_B, 32'h0000_0041, 32'h0);
        data_access(1'b0, mem_ctl_pkg::OP_HU, 32'h0000_0042, 32'h0);

        // Data accesses that preempt a running fetch
        set_instr(32'h0800);
        repeat (20) @(posedge clk);
        data_access(1'b0, mem_ctl_pkg::OP_W, RAM_BASE + 32'h300, 32'h0);
        wait_instr();
        repeat (10) @(posedge clk);
        data_access(1'b1, mem_ctl_pkg::OP_W, RAM_BASE + 32'h310, 32'h5566_7788);
        data_access(1'b0, mem_ctl_pkg::OP_W, RAM_BASE + 32'h310, 32'h0);
        fetch(32'h0804, 1'b0);
        repeat (DWELL) @(posedge clk);
        data_access(1'b0, mem_ctl_pkg::OP_H, 32'h0000_0123, 32'h0);
        fetch(32'h0808, 1'b0);

        // Random mix
        for (int n = 0; n < RANDOM_OPS; n++) begin
            sel = rand_bits(2);
            off = rand_bits(14);
            case (sel[1:0])
                2'd0: fetch(instr_addr + 32'd4, 1'b0);
                2'd1: fetch(rand_bits(12) << 2, 1'b0);
                2'd2: begin
                    case (rand_bits(3) % 5)
                        0:       op = mem_ctl_pkg::OP_B;
                        1:       op = mem_ctl_pkg::OP_H;
                        2:       op = mem_ctl_pkg::OP_W;
                        3:       op = mem_ctl_pkg::OP_BU;
                        default: op = mem_ctl_pkg::OP_HU;
                    endcase
                    data_access(1'b0, op, (rand_bits(1) ? RAM_BASE : 32'h0) | off, 32'h0);
                end
                default: begin
                    case (rand_bits(2) % 3)
                        0:       op = mem_ctl_pkg::OP_B;
                        1:       op = mem_ctl_pkg::OP_H;
                        default: op = mem_ctl_pkg::OP_W;
                    endcase
                    data_access(1'b1, op, RAM_BASE | off, rand_bits(32));
                end
            endcase
        end

        repeat (5) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sources.f
source/mem_ctl_pkg.sv
source/data_lane_align.sv
source/prefetch_buffer.sv
source/access_sequencer.sv
source/spi_engine.sv
source/mem_ctl_top.sv
tests/spi_mem_model.sv
tests/mem_ctl_properties.sv
tests/mem_ctl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module mem_ctl_tb -o mem_ctl_sim \
    && ./obj_dir/mem_ctl_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
